// File: verilog/host_mem_pkg.sv
// Sizes and shared types for the accelerator-to-host read path adapter
package host_mem_pkg;

    // Byte address width on both sides
    localparam int ADDR_W = 32;

    // One line is 64 bits, or 8 bytes
    localparam int DATA_W = 64;

    // Byte offset bits inside a line
    localparam int LINE_OFS_W = 3;

    // Accelerator burst length field, beats are the value plus one
    localparam int AFU_LEN_W = 8;

    // Host burst length field, beats are the value plus one
    localparam int HOST_LEN_W = 2;

    // Largest host burst, also the alignment unit in lines
    localparam int HOST_MAX_BEATS = 4;

    // Accelerator AXI ID width
    localparam int ID_W = 4;

    // Reorder buffer size and index width
    // The index doubles as the host request and response ID
    localparam int ROB_DEPTH = 32;
    localparam int ROB_IDX_W = 5;

    // Credit counter has to hold every value from 0 to ROB_DEPTH
    localparam int CREDIT_W = 6;

    // Burst mapper states
    typedef enum logic [0:0]
    {
        MAP_IDLE,
        MAP_SPLIT
    } map_state_t;

endpackage

// File: verilog/host_mem_burst_map.sv
`timescale 1ns/1ps

module host_mem_burst_map import host_mem_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,

    // Accelerator read request
    input  logic                  ar_valid,
    output logic                  ar_ready,
    input  logic [ADDR_W-1:0]     ar_addr,
    input  logic [AFU_LEN_W-1:0]  ar_len,
    input  logic [ID_W-1:0]       ar_id,

    // Host-sized pieces toward the credit stage
    output logic                  map_valid,
    input  logic                  map_ready,
    output logic [ADDR_W-1:0]     map_addr,
    output logic [HOST_LEN_W-1:0] map_len,
    output logic [ID_W-1:0]       map_id,
    output logic                  map_last
);

    map_state_t state;

    // Byte address of the next piece and beats still to issue
    logic [ADDR_W-1:0]      cur_addr;
    logic [AFU_LEN_W:0]     beats_left;
    logic [ID_W-1:0]        cur_id;

    // Position of the current line inside its four-line group
    logic [HOST_LEN_W-1:0]  line_in_group;
    // Lines left until the next four-line boundary, 1 to 4
    logic [HOST_LEN_W:0]    to_boundary;
    logic [HOST_LEN_W:0]    piece_beats;

    assign line_in_group = cur_addr[LINE_OFS_W +: HOST_LEN_W];
    assign to_boundary   = (HOST_LEN_W + 1)'(HOST_MAX_BEATS) - {1'b0, line_in_group};

    // The burst ends inside this group, so this piece is the final one
    assign map_last    = beats_left <= (AFU_LEN_W + 1)'(to_boundary);
    // On the final piece beats_left is at most 4 and fits the narrow field
    assign piece_beats = map_last ? beats_left[HOST_LEN_W:0] : to_boundary;

    // New requests are taken only between bursts
    assign ar_ready  = (state == MAP_IDLE);
    assign map_valid = (state == MAP_SPLIT);
    assign map_addr  = cur_addr;
    assign map_len   = HOST_LEN_W'(piece_beats - 1'b1);
    assign map_id    = cur_id;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state <= MAP_IDLE;
        end
        else
        begin
            case (state)
                MAP_IDLE:
                begin
                    if (ar_valid)
                    begin
                        state <= MAP_SPLIT;
                    end
                end
                MAP_SPLIT:
                begin
                    // Go back to idle once the last piece has left
                    if (map_ready && map_last)
                    begin
                        state <= MAP_IDLE;
                    end
                end
                default:
                begin
                    state <= MAP_IDLE;
                end
            endcase
        end
    end

    // Address, length and ID of the burst being split
    always_ff @(posedge clk)
    begin
        if (ar_valid && ar_ready)
        begin
            cur_addr   <= ar_addr;
            beats_left <= {1'b0, ar_len} + 1'b1;
            cur_id     <= ar_id;
        end
        else if (map_valid && map_ready)
        begin
            // Step past the lines that were just handed on
            cur_addr   <= cur_addr + (ADDR_W'(piece_beats) << LINE_OFS_W);
            beats_left <= beats_left - (AFU_LEN_W + 1)'(piece_beats);
        end
    end

    // The splitting arithmetic assumes line-aligned accelerator addresses
    a_ar_line_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        (ar_valid && ar_ready) |-> (ar_addr[LINE_OFS_W-1:0] == '0))
        else $error("Accelerator read address %h is not line aligned", ar_addr);

endmodule

// File: verilog/host_mem_rsp_credits.sv
`timescale 1ns/1ps

module host_mem_rsp_credits import host_mem_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,

    // Request from the burst mapper
    input  logic                  map_valid,
    output logic                  map_ready,
    input  logic [HOST_LEN_W-1:0] map_len,

    // Gated request toward the host
    output logic                  host_ar_valid,
    input  logic                  host_ar_ready,

    // One pulse per beat handed to the accelerator
    input  logic                  rob_free
);

    // Free ROB slots, starts full
    logic [CREDIT_W-1:0]   credits;
    logic [HOST_LEN_W:0]   req_beats;
    logic                  enough;
    logic                  take;

    assign req_beats = {1'b0, map_len} + 1'b1;

    // The host response channel can't stall, so a request goes out only
    // when every one of its beats already owns a slot
    assign enough = credits >= CREDIT_W'(req_beats);

    assign host_ar_valid = map_valid && enough;
    assign map_ready     = enough && host_ar_ready;

    assign take = host_ar_valid && host_ar_ready;

    // Spend and refund may land in the same cycle
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            credits <= CREDIT_W'(ROB_DEPTH);
        end
        else
        begin
            credits <= credits - (take ? CREDIT_W'(req_beats) : '0) +
                       (rob_free ? CREDIT_W'(1) : '0);
        end
    end

    // More refunds than beats issued would mean the ROB freed a slot twice
    a_credit_bound: assert property (@(posedge clk) disable iff (!arst_n)
        credits <= CREDIT_W'(ROB_DEPTH))
        else $error("Credit count %0d exceeds ROB depth", credits);

endmodule

// File: verilog/host_mem_rob.sv
`timescale 1ns/1ps

module host_mem_rob import host_mem_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,

    // Host request handshake and the fields needed to allocate
    input  logic                  host_ar_valid,
    input  logic                  host_ar_ready,
    input  logic [HOST_LEN_W-1:0] map_len,
    input  logic [ID_W-1:0]       map_id,
    input  logic                  map_last,
    output logic [ROB_IDX_W-1:0]  host_ar_id,

    // Host responses, no back-pressure possible
    input  logic                  host_r_valid,
    input  logic [DATA_W-1:0]     host_r_data,
    input  logic [ROB_IDX_W-1:0]  host_r_id,

    // In-order responses to the accelerator
    output logic                  r_valid,
    input  logic                  r_ready,
    output logic [DATA_W-1:0]     r_data,
    output logic [ID_W-1:0]       r_id,
    output logic                  r_last,

    // Credit refund, one per delivered beat
    output logic                  rob_free
);

    logic [DATA_W-1:0]     slot_data [ROB_DEPTH];
    logic [ID_W-1:0]       slot_id   [ROB_DEPTH];
    logic [ROB_DEPTH-1:0]  slot_last;

    // Slot owned by an outstanding request, and slot holding host data
    logic [ROB_DEPTH-1:0]  slot_alloc;
    logic [ROB_DEPTH-1:0]  slot_valid;

    logic [ROB_IDX_W-1:0]  tail;
    logic [ROB_IDX_W-1:0]  head;
    logic [ROB_IDX_W-1:0]  last_idx;

    logic                  alloc;
    logic [ROB_DEPTH-1:0]  alloc_mask;
    logic                  load;

    assign alloc      = host_ar_valid && host_ar_ready;
    assign host_ar_id = tail;
    assign last_idx   = tail + ROB_IDX_W'(map_len);

    // Refill the output stage whenever it is empty or being drained
    assign load     = slot_valid[head] && (!r_valid || r_ready);
    assign rob_free = r_valid && r_ready;

    // Consecutive slots from the tail, wrapping at ROB_DEPTH
    always_comb
    begin
        logic [ROB_IDX_W-1:0] slot;
        alloc_mask = '0;
        for (int i = 0; i < HOST_MAX_BEATS; i++)
        begin
            slot = tail + ROB_IDX_W'(i);
            if (i <= int'(map_len))
            begin
                alloc_mask[slot] = alloc;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            tail       <= '0;
            head       <= '0;
            slot_alloc <= '0;
            slot_valid <= '0;
            r_valid    <= 1'b0;
        end
        else
        begin
            if (alloc)
            begin
                tail <= tail + ROB_IDX_W'(map_len) + 1'b1;
            end
            // The head slot is released as soon as it moves to the output stage
            if (load)
            begin
                head             <= head + 1'b1;
                slot_valid[head] <= 1'b0;
            end
            slot_alloc <= (slot_alloc & ~(load ? ROB_DEPTH'(1) << head : '0)) | alloc_mask;
            if (host_r_valid)
            begin
                slot_valid[host_r_id] <= 1'b1;
            end
            if (load)
            begin
                r_valid <= 1'b1;
            end
            else if (r_ready)
            begin
                r_valid <= 1'b0;
            end
        end
    end

    // Slot contents and the output stage payload
    always_ff @(posedge clk)
    begin
        for (int j = 0; j < ROB_DEPTH; j++)
        begin
            if (alloc_mask[j])
            begin
                slot_id[j]   <= map_id;
                slot_last[j] <= map_last && (ROB_IDX_W'(j) == last_idx);
            end
        end
        if (host_r_valid)
        begin
            slot_data[host_r_id] <= host_r_data;
        end
        if (load)
        begin
            r_data <= slot_data[head];
            r_id   <= slot_id[head];
            r_last <= slot_last[head];
        end
    end

    // Credits upstream must keep allocation from reaching data not yet drained
    a_alloc_free: assert property (@(posedge clk) disable iff (!arst_n)
        alloc |-> ((alloc_mask & slot_valid) == '0))
        else $error("ROB allocation overlaps a filled slot");

    // Host beats must target a slot that was requested and is still empty
    a_rsp_slot: assert property (@(posedge clk) disable iff (!arst_n)
        host_r_valid |-> (slot_alloc[host_r_id] && !slot_valid[host_r_id]))
        else $error("Host response id %0d hits an unexpected slot", host_r_id);

endmodule

// File: verilog/map_axi_rd_to_host_mem.sv
`timescale 1ns/1ps

module map_axi_rd_to_host_mem import host_mem_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,

    // Accelerator read request
    input  logic                  ar_valid,
    output logic                  ar_ready,
    input  logic [ADDR_W-1:0]     ar_addr,
    input  logic [AFU_LEN_W-1:0]  ar_len,
    input  logic [ID_W-1:0]       ar_id,

    // Accelerator read response, in request order
    output logic                  r_valid,
    input  logic                  r_ready,
    output logic [DATA_W-1:0]     r_data,
    output logic [ID_W-1:0]       r_id,
    output logic                  r_last,

    // Host read request, IDs are ROB indices
    output logic                  host_ar_valid,
    input  logic                  host_ar_ready,
    output logic [ADDR_W-1:0]     host_ar_addr,
    output logic [HOST_LEN_W-1:0] host_ar_len,
    output logic [ROB_IDX_W-1:0]  host_ar_id,

    // Host read response, any order, no flow control
    input  logic                  host_r_valid,
    input  logic [DATA_W-1:0]     host_r_data,
    input  logic [ROB_IDX_W-1:0]  host_r_id
);

    // Pieces leaving the burst mapper
    logic                  map_valid;
    logic                  map_ready;
    logic [ID_W-1:0]       map_id;
    logic                  map_last;

    // Refund from the ROB to the credit counter
    logic                  rob_free;

    // Cut accelerator bursts into aligned host bursts of up to four lines
    // Address and length go to the host unchanged
    host_mem_burst_map map_bursts
    (
        .clk       (clk),
        .arst_n    (arst_n),
        .ar_valid  (ar_valid),
        .ar_ready  (ar_ready),
        .ar_addr   (ar_addr),
        .ar_len    (ar_len),
        .ar_id     (ar_id),
        .map_valid (map_valid),
        .map_ready (map_ready),
        .map_addr  (host_ar_addr),
        .map_len   (host_ar_len),
        .map_id    (map_id),
        .map_last  (map_last)
    );

    // Hold back requests until the ROB can absorb every beat
    host_mem_rsp_credits rsp_credits
    (
        .clk           (clk),
        .arst_n        (arst_n),
        .map_valid     (map_valid),
        .map_ready     (map_ready),
        .map_len       (host_ar_len),
        .host_ar_valid (host_ar_valid),
        .host_ar_ready (host_ar_ready),
        .rob_free      (rob_free)
    );

    // Sort host beats back into request order
    host_mem_rob rob
    (
        .clk           (clk),
        .arst_n        (arst_n),
        .host_ar_valid (host_ar_valid),
        .host_ar_ready (host_ar_ready),
        .map_len       (host_ar_len),
        .map_id        (map_id),
        .map_last      (map_last),
        .host_ar_id    (host_ar_id),
        .host_r_valid  (host_r_valid),
        .host_r_data   (host_r_data),
        .host_r_id     (host_r_id),
        .r_valid       (r_valid),
        .r_ready       (r_ready),
        .r_data        (r_data),
        .r_id          (r_id),
        .r_last        (r_last),
        .rob_free      (rob_free)
    );

endmodule

// File: tests/tb_map_axi_rd_to_host_mem.sv
`timescale 1ns/1ps

module tb_map_axi_rd_to_host_mem import host_mem_pkg::*;
();

    localparam int N_SINGLE = 24;
    localparam int N_LONG   = 8;
    localparam int N_OOO    = 12;
    localparam int N_STALL  = 6;
    // Every burst outside the single-beat test may be 256 beats long
    localparam int MAX_BEATS       = N_SINGLE + (N_LONG + N_OOO + N_STALL) * 256;
    localparam int CYCLES_PER_BEAT = 32;
    localparam int WATCHDOG_CYCLES = MAX_BEATS * CYCLES_PER_BEAT + 1000;
    // Host memory content is the line address XOR this pattern
    localparam logic [DATA_W-1:0] DATA_PATTERN = 64'h5a3c_96e1_0f87_c3d2;

    logic                  clk;
    logic                  arst_n;
    logic                  ar_valid;
    logic                  ar_ready;
    logic [ADDR_W-1:0]     ar_addr;
    logic [AFU_LEN_W-1:0]  ar_len;
    logic [ID_W-1:0]       ar_id;
    logic                  r_valid;
    logic                  r_ready;
    logic [DATA_W-1:0]     r_data;
    logic [ID_W-1:0]       r_id;
    logic                  r_last;
    logic                  host_ar_valid;
    logic                  host_ar_ready;
    logic [ADDR_W-1:0]     host_ar_addr;
    logic [HOST_LEN_W-1:0] host_ar_len;
    logic [ROB_IDX_W-1:0]  host_ar_id;
    logic                  host_r_valid;
    logic [DATA_W-1:0]     host_r_data;
    logic [ROB_IDX_W-1:0]  host_r_id;

    integer seed = 32'ha35c;

    // Beats the accelerator should see, in request order
    logic [DATA_W-1:0]     exp_data [$];
    logic [ID_W-1:0]       exp_id [$];
    logic                  exp_last [$];
    // Accelerator bursts still being cut into host pieces
    logic [ADDR_W-1:0]     burst_addr [$];
    int                    burst_beats [$];
    // Host beats requested but not yet returned
    logic [ROB_IDX_W-1:0]  pend_id [$];
    logic [DATA_W-1:0]     pend_data [$];
    // ROB index that the next host request should start at
    logic [ROB_IDX_W-1:0]  next_host_id = '0;

    int checks = 0;
    int errors = 0;
    int cycle = 0;
    int outstanding = 0;
    int max_outstanding = 0;
    // Traffic knobs, in percent per cycle
    int hrdy_pct = 100;
    int rsp_pct = 100;
    int rrdy_pct = 100;
    bit stall_mode = 1'b0;

    map_axi_rd_to_host_mem map_axi_rd_to_host_mem_inst
    (
        .clk           (clk),
        .arst_n        (arst_n),
        .ar_valid      (ar_valid),
        .ar_ready      (ar_ready),
        .ar_addr       (ar_addr),
        .ar_len        (ar_len),
        .ar_id         (ar_id),
        .r_valid       (r_valid),
        .r_ready       (r_ready),
        .r_data        (r_data),
        .r_id          (r_id),
        .r_last        (r_last),
        .host_ar_valid (host_ar_valid),
        .host_ar_ready (host_ar_ready),
        .host_ar_addr  (host_ar_addr),
        .host_ar_len   (host_ar_len),
        .host_ar_id    (host_ar_id),
        .host_r_valid  (host_r_valid),
        .host_r_data   (host_r_data),
        .host_r_id     (host_r_id)
    );

    always #2 clk = ~clk;

    function automatic int rand_below(int n);
        logic [31:0] v;
        v = $random(seed);
        return int'(v % n);
    endfunction

    function automatic logic [ADDR_W-1:0] rand_line_addr();
        logic [ADDR_W-1:0] a;
        a = ADDR_W'($random(seed));
        a[LINE_OFS_W-1:0] = '0;
        return a;
    endfunction

    function automatic logic [DATA_W-1:0] model_line_data(logic [ADDR_W-1:0] addr);
        return DATA_W'(addr) ^ DATA_PATTERN;
    endfunction

    task automatic check_value(string name, logic [63:0] got, logic [63:0] expected);
        checks++;
        if (got !== expected)
        begin
            errors++;
            $display("[FAIL] %s: got 0x%h, expected 0x%h at %0t", name, got, expected, $time);
        end
    endtask

    // Random values are drawn on the falling edge so they never race the monitor
    task automatic send_burst(int max_len);
        logic [ADDR_W-1:0]    addr;
        logic [AFU_LEN_W-1:0] len;
        logic [ID_W-1:0]      id;
        @(negedge clk);
        addr = rand_line_addr();
        len  = AFU_LEN_W'(rand_below(max_len + 1));
        id   = ID_W'(rand_below(1 << ID_W));
        @(posedge clk);
        ar_valid <= 1'b1;
        ar_addr  <= addr;
        ar_len   <= len;
        ar_id    <= id;
        do
        begin
            @(posedge clk);
        end while (!ar_ready);
        ar_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        @(negedge clk);
        while (exp_data.size() != 0 || burst_beats.size() != 0 || pend_id.size() != 0)
        begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
    endtask

    task automatic report_test(int num, string name, int err_before);
        $display("test %0d %s: %0d errors", num, name, errors - err_before);
    endtask

    // Host memory model and monitors for both sides of the DUT
    always @(posedge clk)
    begin
        int k;
        int pick;
        int exp_beats;
        int to_bnd;
        logic [ADDR_W-1:0] line;
        if (arst_n)
        begin
            cycle++;
            // Every accepted accelerator burst expands into its expected beats
            if (ar_valid && ar_ready)
            begin
                for (k = 0; k <= int'(ar_len); k++)
                begin
                    exp_data.push_back(model_line_data(ar_addr + ADDR_W'(k << LINE_OFS_W)));
                    exp_id.push_back(ar_id);
                    exp_last.push_back(k == int'(ar_len));
                end
                burst_addr.push_back(ar_addr);
                burst_beats.push_back(int'(ar_len) + 1);
            end
            if (host_ar_valid && host_ar_ready)
            begin
                if (burst_beats.size() == 0)
                begin
                    errors++;
                    $display("Host request at %0t with no accelerator burst pending", $time);
                end
                else
                begin
                    // A piece stops at the next four-line group or at the burst end
                    line      = burst_addr[0] >> LINE_OFS_W;
                    to_bnd    = HOST_MAX_BEATS - int'(line % ADDR_W'(HOST_MAX_BEATS));
                    exp_beats = (burst_beats[0] < to_bnd) ? burst_beats[0] : to_bnd;
                    check_value("host_ar_addr", 64'(host_ar_addr), 64'(burst_addr[0]));
                    check_value("host_ar_len", 64'(host_ar_len), 64'(exp_beats - 1));
                    burst_addr[0]  = burst_addr[0] + ADDR_W'((int'(host_ar_len) + 1) << LINE_OFS_W);
                    burst_beats[0] = burst_beats[0] - (int'(host_ar_len) + 1);
                    if (burst_beats[0] <= 0)
                    begin
                        void'(burst_addr.pop_front());
                        void'(burst_beats.pop_front());
                    end
                end
                // Slots are handed out back to back, so each id follows the last request
                check_value("host_ar_id", 64'(host_ar_id), 64'(next_host_id));
                next_host_id = next_host_id + ROB_IDX_W'(int'(host_ar_len) + 1);
                // Beat k comes back tagged with the request id plus k
                for (k = 0; k <= int'(host_ar_len); k++)
                begin
                    pend_id.push_back(host_ar_id + ROB_IDX_W'(k));
                    pend_data.push_back(model_line_data(host_ar_addr + ADDR_W'(k << LINE_OFS_W)));
                end
                outstanding += int'(host_ar_len) + 1;
            end
            if (r_valid && r_ready)
            begin
                if (exp_data.size() == 0)
                begin
                    errors++;
                    $display("Accelerator beat at %0t arrived with nothing expected", $time);
                end
                else
                begin
                    check_value("r_data", 64'(r_data), 64'(exp_data.pop_front()));
                    check_value("r_id", 64'(r_id), 64'(exp_id.pop_front()));
                    check_value("r_last", 64'(r_last), 64'(exp_last.pop_front()));
                end
                outstanding--;
            end
            if (outstanding > ROB_DEPTH)
            begin
                errors++;
                $display("Outstanding host beats %0d exceed the ROB at %0t", outstanding, $time);
            end
            if (outstanding > max_outstanding)
            begin
                max_outstanding = outstanding;
            end
            host_ar_ready <= (rand_below(100) < hrdy_pct);
            // Any pending beat may be the next one returned
            host_r_valid <= 1'b0;
            if (pend_id.size() != 0 && rand_below(100) < rsp_pct)
            begin
                pick = rand_below(pend_id.size());
                host_r_valid <= 1'b1;
                host_r_id    <= pend_id[pick];
                host_r_data  <= pend_data[pick];
                pend_id.delete(pick);
                pend_data.delete(pick);
            end
            if (stall_mode && (cycle % 300) < 220)
            begin
                r_ready <= 1'b0;
            end
            else
            begin
                r_ready <= (rand_below(100) < rrdy_pct);
            end
        end
    end

    initial
    begin
        int err_before;
        clk           = 1'b0;
        arst_n        = 1'b0;
        ar_valid      = 1'b0;
        ar_addr       = '0;
        ar_len        = '0;
        ar_id         = '0;
        r_ready       = 1'b0;
        host_ar_ready = 1'b0;
        host_r_valid  = 1'b0;
        host_r_data   = '0;
        host_r_id     = '0;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;

        err_before = errors;
        @(negedge clk);
        check_value("ar_ready", 64'(ar_ready), 64'(1));
        check_value("r_valid", 64'(r_valid), 64'(0));
        check_value("host_ar_valid", 64'(host_ar_valid), 64'(0));
        check_value("map_state", 64'(map_axi_rd_to_host_mem_inst.map_bursts.state),
                    64'(MAP_IDLE));
        report_test(1, "reset values", err_before);

        err_before = errors;
        repeat (N_SINGLE) send_burst(0);
        wait_drain();
        report_test(2, "single-beat reads", err_before);

        err_before = errors;
        hrdy_pct = 70;
        rsp_pct  = 60;
        rrdy_pct = 90;
        repeat (N_LONG) send_burst(255);
        wait_drain();
        report_test(3, "long bursts split into host pieces", err_before);

        // Slow random returns let many beats pile up and come back shuffled
        err_before = errors;
        hrdy_pct = 90;
        rsp_pct  = 20;
        rrdy_pct = 80;
        repeat (N_OOO) send_burst(63);
        wait_drain();
        report_test(4, "out-of-order host responses", err_before);

        err_before = errors;
        max_outstanding = 0;
        hrdy_pct   = 90;
        rsp_pct    = 80;
        rrdy_pct   = 50;
        stall_mode = 1'b1;
        repeat (N_STALL) send_burst(255);
        wait_drain();
        stall_mode = 1'b0;
        report_test(5, "accelerator back-pressure", err_before);
        $display("peak outstanding host beats %0d of %0d", max_outstanding, ROB_DEPTH);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
        begin
            $display("Everything OK");
        end
        else
        begin
            $display("Something failed");
        end
        $finish;
    end

    // Bound the run by the largest amount of traffic the tests can issue
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, traffic never drained", WATCHDOG_CYCLES);
        $display("Something failed");
        $finish;
    end

endmodule

// File: map_axi_rd_to_host_mem.f
verilog/host_mem_pkg.sv
verilog/host_mem_burst_map.sv
verilog/host_mem_rsp_credits.sv
verilog/host_mem_rob.sv
verilog/map_axi_rd_to_host_mem.sv
tests/tb_map_axi_rd_to_host_mem.sv

// File: Makefile
VERILATOR  ?= verilator
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
TB_TOP     := tb_map_axi_rd_to_host_mem
DUT_TOP    := map_axi_rd_to_host_mem
FILELIST   := map_axi_rd_to_host_mem.f
OBJ_DIR    := obj_dir
PASS_TEXT  := Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(OBJ_DIR) --top-module $(TB_TOP) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_TEXT)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
